/* source/mem_sys_pkg.sv */
package mem_sys_pkg;

   // Address split for 16-bit byte addresses
   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 3;

   // One word per bank in a line fill
   localparam int WORDS_PER_LINE = 4;

   // Overlays a full byte address, tag in the top bits
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;   // Bits 2:1 pick the word, bit 0 must be zero
   } line_addr_t;

   // Controller to bank memory
   typedef struct packed {
      logic [15:0] addr;
      logic [15:0] data;
      logic        rd;
      logic        wr;
   } mem_req_t;

   // Read return, address comes back with the data
   typedef struct packed {
      logic [15:0] data;
      logic [15:0] addr;
      logic        valid;
   } mem_rsp_t;

endpackage

/* source/cache_array.sv */
`timescale 1ns/1ns

module cache_array (
   input  logic                    clk,
   input  logic                    rst,
   input  mem_sys_pkg::line_addr_t addr,
   input  logic                    word_we,
   input  logic [15:0]             word_in,
   input  logic                    fill_we,
   input  logic [1:0]              fill_word,
   input  logic [15:0]             fill_data,
   input  logic                    fill_last,
   output logic                    hit,
   output logic [15:0]             data_out
);

   import mem_sys_pkg::*;

   localparam int LINES = 2**INDEX_W;

   logic [TAG_W-1:0] tags [LINES];
   logic [LINES-1:0] valid;
   logic [15:0]      data [LINES][WORDS_PER_LINE];

   logic [1:0]         word_sel;
   logic [TAG_W-1:0]   tag_rd;
   logic [INDEX_W-1:0] idx;

   assign idx      = addr.index;
   assign word_sel = addr.offset[OFFSET_W-1:1];
   assign tag_rd   = tags[idx];

   // Combinational lookup
   assign hit      = valid[idx] && (tag_rd == addr.tag);
   assign data_out = data[idx][word_sel];

   // A line only turns valid once its last fill word lands
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (fill_we) begin
         valid[idx] <= fill_last;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_we) begin
         tags[idx]            <= addr.tag;
         data[idx][fill_word] <= fill_data;
      end else if (word_we && hit) begin
         data[idx][word_sel] <= word_in;   // Write-through hit update
      end
   end

endmodule

/* source/bank_memory.sv */
`timescale 1ns/1ns

module bank_memory #(
   parameter int MEM_LATENCY = 3,
   parameter int BANK_CYCLES = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_sys_pkg::mem_req_t req,
   output logic                  stall,
   output mem_sys_pkg::mem_rsp_t rsp
);

   import mem_sys_pkg::*;

   localparam int ROWS   = 2**(TAG_W + INDEX_W);
   localparam int BANK_W = $clog2(WORDS_PER_LINE);
   localparam int CNT_W  = (BANK_CYCLES > 1) ? $clog2(BANK_CYCLES + 1) : 1;

   localparam logic [CNT_W-1:0] BUSY_LOAD = CNT_W'(BANK_CYCLES);

   logic [15:0] banks [WORDS_PER_LINE][ROWS];

   logic [CNT_W-1:0] busy [WORDS_PER_LINE];

   mem_rsp_t pipe [MEM_LATENCY];

   line_addr_t                  a;
   logic [BANK_W-1:0]           bank;
   logic [TAG_W+INDEX_W-1:0]    row;
   logic                        req_any;
   logic                        accept;
   logic                        accept_rd;
   logic                        accept_wr;

   assign a    = req.addr;
   assign bank = a.offset[OFFSET_W-1:1];   // Low word bits interleave the banks
   assign row  = {a.tag, a.index};

   assign req_any   = req.rd | req.wr;
   assign stall     = req_any && (busy[bank] != '0);
   assign accept    = req_any && !stall;
   assign accept_rd = accept && req.rd;
   assign accept_wr = accept && req.wr;

   // Per-bank busy down-counters
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= '{default: '0};
      end else begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            if (accept && (int'(bank) == b)) begin
               busy[b] <= BUSY_LOAD;
            end else if (busy[b] != '0) begin
               busy[b] <= busy[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept_wr) begin
         banks[bank][row] <= req.data;
      end
   end

   // Fixed-latency read return
   always_ff @(posedge clk) begin
      pipe[0].data  <= banks[bank][row];
      pipe[0].addr  <= req.addr;
      pipe[0].valid <= accept_rd;
      for (int i = 1; i < MEM_LATENCY; i++) begin
         pipe[i] <= pipe[i-1];
      end
      if (rst) begin
         for (int i = 0; i < MEM_LATENCY; i++) begin
            pipe[i].valid <= 1'b0;
         end
      end
   end

   assign rsp = pipe[MEM_LATENCY-1];

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ns

module cache_controller (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [15:0]             addr,
   input  logic [15:0]             data_in,
   input  logic                    rd,
   input  logic                    wr,
   output logic [15:0]             data_out,
   output logic                    done,
   output logic                    stall,
   output logic                    cache_hit,
   output logic                    err,
   output mem_sys_pkg::line_addr_t cache_addr,
   output logic                    cache_word_we,
   output logic [15:0]             cache_word_in,
   output logic                    cache_fill_we,
   output logic [1:0]              cache_fill_word,
   output logic [15:0]             cache_fill_data,
   output logic                    cache_fill_last,
   input  logic                    cache_line_hit,
   input  logic [15:0]             cache_data_out,
   output mem_sys_pkg::mem_req_t   mem_req,
   input  logic                    mem_stall,
   input  mem_sys_pkg::mem_rsp_t   mem_rsp
);

   import mem_sys_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      MEM_WRITE,
      FILL_ISSUE,
      FILL_WAIT,
      FINISH
   } state_t;

   localparam logic [1:0] LAST_WORD = 2'(WORDS_PER_LINE - 1);

   state_t     state, state_nxt;
   mem_req_t   req_q;         // Captured request
   logic [1:0] issue_cnt;
   logic [1:0] rsp_cnt;
   logic       hit_q;
   logic       err_q;
   logic       req_err;
   logic       filling;
   line_addr_t fill_addr;

   assign req_err = (req_q.rd & req_q.wr) | req_q.addr[0];
   assign filling = (state == FILL_ISSUE) || (state == FILL_WAIT);

   always_ff @(posedge clk) begin
      if (state == IDLE && (rd || wr)) begin
         req_q.addr <= addr;
         req_q.data <= data_in;
         req_q.rd   <= rd;
         req_q.wr   <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         issue_cnt <= '0;
         rsp_cnt   <= '0;
         hit_q     <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == LOOKUP) begin
            hit_q     <= cache_line_hit & ~req_err;
            err_q     <= req_err;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
         end
         if (state == FILL_ISSUE && !mem_stall) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (filling && mem_rsp.valid) begin
            rsp_cnt <= rsp_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:       if (rd || wr) state_nxt = LOOKUP;
         LOOKUP: begin
            if (req_err) begin
               state_nxt = FINISH;
            end else if (req_q.wr) begin
               state_nxt = MEM_WRITE;   // Memory always takes the write
            end else if (cache_line_hit) begin
               state_nxt = FINISH;
            end else begin
               state_nxt = FILL_ISSUE;
            end
         end
         MEM_WRITE:  if (!mem_stall) state_nxt = hit_q ? FINISH : FILL_ISSUE;
         FILL_ISSUE: if (!mem_stall && issue_cnt == LAST_WORD) state_nxt = FILL_WAIT;
         FILL_WAIT:  if (mem_rsp.valid && rsp_cnt == LAST_WORD) state_nxt = FINISH;
         FINISH:     state_nxt = IDLE;
         default:    state_nxt = IDLE;
      endcase
   end

   // Fill walks the line one bank at a time
   always_comb begin
      fill_addr        = req_q.addr;
      fill_addr.offset = {issue_cnt, 1'b0};
   end

   always_comb begin
      mem_req = '0;
      if (state == MEM_WRITE) begin
         mem_req.addr = req_q.addr;
         mem_req.data = req_q.data;
         mem_req.wr   = 1'b1;
      end else if (state == FILL_ISSUE) begin
         mem_req.addr = fill_addr;
         mem_req.rd   = 1'b1;
      end
   end

   assign cache_addr      = req_q.addr;
   assign cache_word_we   = (state == LOOKUP) && req_q.wr && !req_err;
   assign cache_word_in   = req_q.data;
   assign cache_fill_we   = filling && mem_rsp.valid;
   assign cache_fill_word = mem_rsp.addr[2:1];   // Returns land by their own address
   assign cache_fill_data = mem_rsp.data;
   assign cache_fill_last = (rsp_cnt == LAST_WORD);

   assign done      = (state == FINISH);
   assign stall     = (state != IDLE);
   assign data_out  = cache_data_out;
   assign cache_hit = done & hit_q;
   assign err       = done & err_q;

endmodule

/* source/mem_system.sv */
`timescale 1ns/1ns

module mem_system #(
   parameter int MEM_LATENCY = 3,
   parameter int BANK_CYCLES = 4
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   output logic [15:0] data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   import mem_sys_pkg::*;

   line_addr_t  cache_addr;
   logic        cache_word_we;
   logic [15:0] cache_word_in;
   logic        cache_fill_we;
   logic [1:0]  cache_fill_word;
   logic [15:0] cache_fill_data;
   logic        cache_fill_last;
   logic        cache_line_hit;
   logic [15:0] cache_data_out;
   mem_req_t    mem_req;
   logic        mem_stall;
   mem_rsp_t    mem_rsp;

   cache_controller ctrl (
      .clk             (clk),
      .rst             (rst),
      .addr            (addr),
      .data_in         (data_in),
      .rd              (rd),
      .wr              (wr),
      .data_out        (data_out),
      .done            (done),
      .stall           (stall),
      .cache_hit       (cache_hit),
      .err             (err),
      .cache_addr      (cache_addr),
      .cache_word_we   (cache_word_we),
      .cache_word_in   (cache_word_in),
      .cache_fill_we   (cache_fill_we),
      .cache_fill_word (cache_fill_word),
      .cache_fill_data (cache_fill_data),
      .cache_fill_last (cache_fill_last),
      .cache_line_hit  (cache_line_hit),
      .cache_data_out  (cache_data_out),
      .mem_req         (mem_req),
      .mem_stall       (mem_stall),
      .mem_rsp         (mem_rsp)
   );

   cache_array cache (
      .clk       (clk),
      .rst       (rst),
      .addr      (cache_addr),
      .word_we   (cache_word_we),
      .word_in   (cache_word_in),
      .fill_we   (cache_fill_we),
      .fill_word (cache_fill_word),
      .fill_data (cache_fill_data),
      .fill_last (cache_fill_last),
      .hit       (cache_line_hit),
      .data_out  (cache_data_out)
   );

   bank_memory #(
      .MEM_LATENCY (MEM_LATENCY),
      .BANK_CYCLES (BANK_CYCLES)
   ) mem (
      .clk   (clk),
      .rst   (rst),
      .req   (mem_req),
      .stall (mem_stall),
      .rsp   (mem_rsp)
   );

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Synchronous reset, released on a rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

/* sim/mem_system_tb.sv */
`timescale 1ns/1ns

module mem_system_tb;

   import mem_sys_pkg::*;

   localparam int PERIOD         = 8;
   localparam int NUM_REQUESTS   = 420;
   localparam int CYCLES_PER_REQ = 40;
   localparam int DONE_LIMIT     = 100;   // Cycles before a request counts as lost
   localparam int RANDOM_OPS     = 200;

   logic        clk;
   logic        rst;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference model of memory contents and cache tags
   logic [15:0]      ref_mem [logic [15:0]];
   logic [TAG_W-1:0] ref_tag [2**INDEX_W];
   logic             ref_valid [2**INDEX_W];

   int     errors = 0;
   int     checks = 0;
   integer seed   = 74632;

   // Outcome of the most recent request
   logic [15:0] last_data;
   logic        last_hit;
   logic        last_err;
   int          last_lat;

   clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(8)) clocks (.clk(clk), .rst(rst));

   mem_system #(.MEM_LATENCY(3), .BANK_CYCLES(4)) UUT (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   function automatic logic [15:0] make_addr(input logic [TAG_W-1:0] tag,
                                             input logic [INDEX_W-1:0] index,
                                             input logic [1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   task automatic check_equal(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic issue_request(input string name, input logic is_rd, input logic is_wr,
                                input logic [15:0] a, input logic [15:0] d);
      @(posedge clk);
      addr    <= a;
      data_in <= d;
      rd      <= is_rd;
      wr      <= is_wr;
      @(negedge clk);
      checks++;
      assert (!stall) else begin
         errors++;
         $display("%s: DUT still busy when the request was presented", name);
      end
      @(posedge clk);   // Acceptance edge
      rd <= 1'b0;
      wr <= 1'b0;
      last_lat = 0;
      do begin
         @(negedge clk);
         last_lat++;
         checks++;
         assert (stall) else begin
            errors++;
            $display("%s: stall low while the request was in progress", name);
         end
      end while (!done && last_lat < DONE_LIMIT);
      checks++;
      assert (done) else begin
         errors++;
         $display("%s: no done within %0d cycles of acceptance", name, DONE_LIMIT);
      end
      last_data = data_out;
      last_hit  = cache_hit;
      last_err  = err;
   endtask

   // Issue one request and compare with the reference model
   task automatic checked_access(input string name, input logic is_rd, input logic is_wr,
                                 input logic [15:0] a, input logic [15:0] d);
      line_addr_t  la;
      logic        exp_err;
      logic        exp_hit;
      logic [15:0] exp_data;
      la       = a;
      exp_err  = (is_rd && is_wr) || a[0];
      exp_hit  = !exp_err && ref_valid[la.index] && (ref_tag[la.index] == la.tag);
      exp_data = ref_mem.exists(a) ? ref_mem[a] : 16'hxxxx;
      issue_request(name, is_rd, is_wr, a, d);
      check_equal({name, " err"}, 16'(exp_err), 16'(last_err));
      check_equal({name, " hit"}, 16'(exp_hit), 16'(last_hit));
      if (is_rd && !exp_err) begin
         check_equal({name, " data"}, exp_data, last_data);
      end
      if (exp_err || (is_rd && exp_hit)) begin
         check_equal({name, " latency"}, 16'd2, 16'(last_lat));
      end
      if (!exp_err) begin   // Reads and writes both allocate
         ref_valid[la.index] = 1'b1;
         ref_tag[la.index]   = la.tag;
         if (is_wr) begin
            ref_mem[a] = d;
         end
      end
   endtask

   task automatic reset_idle_check();
      repeat (10) begin
         @(negedge clk);
         check_equal("reset outputs", 16'd0, 16'({done, err, stall, cache_hit}));
      end
   endtask

   task automatic write_then_read();
      logic [15:0] a;
      a = make_addr(5'd1, 8'h10, 2'd2);
      checked_access("write_read write", 1'b0, 1'b1, a, 16'hbeef);
      check_equal("write_read write hit", 16'd0, 16'(last_hit));
      checked_access("write_read read", 1'b1, 1'b0, a, 16'h0000);
      check_equal("write_read read hit", 16'd1, 16'(last_hit));
      check_equal("write_read read latency", 16'd2, 16'(last_lat));
   endtask

   task automatic line_fill();
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
         checked_access("line_fill write", 1'b0, 1'b1, make_addr(5'd2, 8'h30, 2'(w)),
                        16'h1100 + 16'(w));
      end
      checked_access("line_fill evict", 1'b0, 1'b1, make_addr(5'd6, 8'h30, 2'd1), 16'h5a5a);
      checked_access("line_fill first", 1'b1, 1'b0, make_addr(5'd2, 8'h30, 2'd0), 16'h0000);
      check_equal("line_fill first hit", 16'd0, 16'(last_hit));
      for (int w = 1; w < WORDS_PER_LINE; w++) begin
         checked_access("line_fill rest", 1'b1, 1'b0, make_addr(5'd2, 8'h30, 2'(w)), 16'h0000);
         check_equal("line_fill rest hit", 16'd1, 16'(last_hit));
      end
   endtask

   task automatic conflict_alternation();
      logic [15:0] a;
      logic [15:0] b;
      a = make_addr(5'd3, 8'h20, 2'd0);
      b = make_addr(5'd9, 8'h20, 2'd3);   // Same index, other tag
      checked_access("conflict write a", 1'b0, 1'b1, a, 16'hc0de);
      checked_access("conflict write b", 1'b0, 1'b1, b, 16'hf00d);
      repeat (10) begin
         checked_access("conflict read a", 1'b1, 1'b0, a, 16'h0000);
         check_equal("conflict read a hit", 16'd0, 16'(last_hit));
         checked_access("conflict read b", 1'b1, 1'b0, b, 16'h0000);
         check_equal("conflict read b hit", 16'd0, 16'(last_hit));
      end
   endtask

   task automatic random_traffic();
      logic [15:0] written [$];
      logic [15:0] a;
      logic [15:0] d;
      logic [31:0] pick;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         pick = $random(seed);
         if (written.size() == 0 || pick[0]) begin
            // 2 tags x 8 indexes gives 16 lines with conflicts
            a = make_addr(pick[1] ? 5'd12 : 5'd17, 8'h80 + 8'(pick[4:2]), pick[6:5]);
            d = 16'($random(seed));
            checked_access("random write", 1'b0, 1'b1, a, d);
            written.push_back(a);
         end else begin
            a = written[pick[31:8] % written.size()];
            checked_access("random read", 1'b1, 1'b0, a, 16'h0000);
         end
      end
   endtask

   task automatic error_requests();
      logic [15:0] a;
      logic [15:0] b;
      a = make_addr(5'd4, 8'h50, 2'd1);
      b = make_addr(5'd8, 8'h50, 2'd1);
      checked_access("errors setup", 1'b0, 1'b1, a, 16'h1357);
      checked_access("errors rd and wr", 1'b1, 1'b1, a, 16'hdead);
      check_equal("errors rd and wr flag", 16'd1, 16'(last_err));
      checked_access("errors read after both", 1'b1, 1'b0, a, 16'h0000);
      checked_access("errors odd write", 1'b0, 1'b1, a | 16'h0001, 16'hbad0);
      check_equal("errors odd write flag", 16'd1, 16'(last_err));
      checked_access("errors read after odd", 1'b1, 1'b0, a, 16'h0000);
      checked_access("errors odd read", 1'b1, 1'b0, b | 16'h0001, 16'h0000);
      checked_access("errors other tag", 1'b1, 1'b1, b, 16'h2468);
      checked_access("errors final read", 1'b1, 1'b0, a, 16'h0000);
      check_equal("errors final read hit", 16'd1, 16'(last_hit));
      // Evict the line so the next read of a comes from memory
      checked_access("errors evict", 1'b0, 1'b1, b, 16'h2468);
      checked_access("errors memory read", 1'b1, 1'b0, a, 16'h0000);
   endtask

   initial begin
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      foreach (ref_valid[i]) begin
         ref_valid[i] = 1'b0;
      end
      wait (rst === 1'b0);
      reset_idle_check();
      write_then_read();
      line_fill();
      conflict_alternation();
      random_traffic();
      error_requests();
      @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Worst case about 40 cycles per request
   initial begin
      #(NUM_REQUESTS * CYCLES_PER_REQ * PERIOD + 100 * PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Checks failed");
      $finish;
   end

endmodule

/* filelist.f */
source/mem_sys_pkg.sv
source/cache_array.sv
source/bank_memory.sv
source/cache_controller.sv
source/mem_system.sv
sim/clock_gen.sv
sim/mem_system_tb.sv
